/* flist.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/dbus_if.sv
rtl/lsu.sv
rtl/lsu_csr_apb.sv
rtl/dmem.sv
rtl/lsu_top.sv
verif/tb_clk_gen.sv
verif/tb_lsu_top.sv

/* rtl/dbus_if.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

interface dbus_if;

    // Request side, driven by the LSU
    logic [`XLEN-1:0]     addr;
    logic [`XLEN-1:0]     w_data;
    lsu_pkg::st_ops_e     st_ops;
    logic                 ld_req;
    logic                 st_req;

    // Response side, driven by the memory
    // r_data is the old word, valid with ack
    logic [`XLEN-1:0]     r_data;
    logic                 ack;

    // LSU end of the bus
    modport master (
        output addr,
        output w_data,
        output st_ops,
        output ld_req,
        output st_req,
        input  r_data,
        input  ack
    );

    // Memory end of the bus
    modport slave (
        input  addr,
        input  w_data,
        input  st_ops,
        input  ld_req,
        input  st_req,
        output r_data,
        output ack
    );

endinterface : dbus_if

/* rtl/dmem.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module dmem (
    input  logic     clk,
    input  logic     rst_n_i,
    dbus_if.slave    dbus
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]    mem [`DMEM_WORDS];
    logic [IDX_W-1:0]    idx;
    logic                sample;

    // Word index from address bits above the byte offset
    assign idx = dbus.addr[IDX_W+1:2];

    // New access is taken only while ack is low
    assign sample = (dbus.ld_req | dbus.st_req) & ~dbus.ack;

    // Ack rises one clock after the request is sampled and lasts one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dbus.ack <= 1'b0;
        end else begin
            dbus.ack <= sample;
        end
    end

    // Read returns the word before any write on the same edge
    always_ff @(posedge clk) begin
        if (sample) begin
            dbus.r_data <= mem[idx];
        end
    end

    // Byte-lane write lands on the edge that raises ack
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (sample && dbus.st_req) begin
            case (dbus.st_ops)
                lsu_pkg::ST_OPS_SB: mem[idx][{dbus.addr[1:0], 3'b000} +: 8] <= dbus.w_data[7:0];
                lsu_pkg::ST_OPS_SH: mem[idx][{dbus.addr[1], 4'b0000} +: 16] <= dbus.w_data[15:0];
                lsu_pkg::ST_OPS_SW: mem[idx] <= dbus.w_data;
                default: mem[idx] <= mem[idx];
            endcase
        end
    end

    // Master keeps a sampled request on the bus through the ack cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
        sample |=> ((dbus.ld_req || dbus.st_req) && $stable(dbus.addr)))
        else $error("dmem: request dropped or changed before ack");

endmodule : dmem

/* rtl/lsu.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // Request from execute, held until done_o
    input  lsu_pkg::ld_ops_e     exe_ld_ops_i,
    input  lsu_pkg::st_ops_e     exe_st_ops_i,
    input  logic [`XLEN-1:0]     exe_addr_i,
    input  logic [`XLEN-1:0]     exe_w_data_i,
    input  logic [4:0]           exe_rd_addr_i,

    // Data bus towards memory
    dbus_if.master               dbus,

    // Misalignment check link to the register block
    input  logic                 check_en_i,
    output logic                 fault_o,
    output logic [`XLEN-1:0]     fault_addr_o,

    // Writeback side
    output logic                 done_o,
    output logic                 wrb_valid_o,
    output logic [`XLEN-1:0]     wrb_data_o,
    output logic [4:0]           wrb_rd_addr_o
);

    logic                ld_any;
    logic                st_any;
    logic                ld_misaligned;
    logic                st_misaligned;
    logic [7:0]          rdata_byte;
    logic [15:0]         rdata_hword;

    // Request present when either kind is not NONE
    assign ld_any = (exe_ld_ops_i != lsu_pkg::LD_OPS_NONE);
    assign st_any = (exe_st_ops_i != lsu_pkg::ST_OPS_NONE);

    // Halfword at odd address, or word off a 4-byte boundary
    assign ld_misaligned =
        ((exe_ld_ops_i == lsu_pkg::LD_OPS_LH || exe_ld_ops_i == lsu_pkg::LD_OPS_LHU)
            && exe_addr_i[0]) ||
        ((exe_ld_ops_i == lsu_pkg::LD_OPS_LW) && (|exe_addr_i[1:0]));
    assign st_misaligned =
        ((exe_st_ops_i == lsu_pkg::ST_OPS_SH) && exe_addr_i[0]) ||
        ((exe_st_ops_i == lsu_pkg::ST_OPS_SW) && (|exe_addr_i[1:0]));

    // Fault completes in the first cycle, nothing goes to memory
    assign fault_o      = check_en_i & (ld_misaligned | st_misaligned);
    assign fault_addr_o = exe_addr_i;

    // Bus request, blocked by a fault
    assign dbus.addr   = exe_addr_i;
    assign dbus.w_data = exe_w_data_i;
    assign dbus.st_ops = exe_st_ops_i;
    assign dbus.ld_req = ld_any & ~fault_o;
    assign dbus.st_req = st_any & ~fault_o;

    // Pick the addressed lane out of the returned word
    // With the check off, bit 0 is ignored for halfwords
    always_comb begin
        case (exe_addr_i[1:0])
            2'b00:   rdata_byte = dbus.r_data[7:0];
            2'b01:   rdata_byte = dbus.r_data[15:8];
            2'b10:   rdata_byte = dbus.r_data[23:16];
            default: rdata_byte = dbus.r_data[31:24];
        endcase
        rdata_hword = exe_addr_i[1] ? dbus.r_data[31:16] : dbus.r_data[15:0];
    end

    // Sign or zero extension for writeback
    always_comb begin
        wrb_data_o = '0;
        if (dbus.ack) begin
            case (exe_ld_ops_i)
                lsu_pkg::LD_OPS_LB:  wrb_data_o = {{24{rdata_byte[7]}}, rdata_byte};
                lsu_pkg::LD_OPS_LBU: wrb_data_o = {24'b0, rdata_byte};
                lsu_pkg::LD_OPS_LH:  wrb_data_o = {{16{rdata_hword[15]}}, rdata_hword};
                lsu_pkg::LD_OPS_LHU: wrb_data_o = {16'b0, rdata_hword};
                lsu_pkg::LD_OPS_LW:  wrb_data_o = dbus.r_data;
                default:             wrb_data_o = '0;
            endcase
        end
    end

    // Completion comes from the memory ack or from a fault
    assign done_o        = dbus.ack | fault_o;
    assign wrb_valid_o   = dbus.ack & ld_any;
    assign wrb_rd_addr_o = exe_rd_addr_i;

    // Execute side must never issue a load and a store together
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(dbus.ld_req && dbus.st_req))
        else $error("lsu: load and store requested together");

endmodule : lsu

/* rtl/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width of the core
`define XLEN 32

// Data memory size in 32-bit words
`define DMEM_WORDS 256

// APB byte offsets of the LSU register block
`define REG_CTRL       8'h00
`define REG_FAULT_ADDR 8'h04
`define REG_FAULT_CNT  8'h08

`endif

/* rtl/lsu_csr_apb.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_csr_apb (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // APB slave port
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [7:0]           paddr_i,
    input  logic [`XLEN-1:0]     pwdata_i,
    output logic [`XLEN-1:0]     prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,

    // Fault report from the LSU
    input  logic                 fault_i,
    input  logic [`XLEN-1:0]     fault_addr_i,
    output logic                 check_en_o
);

    lsu_pkg::reg_addr_e      reg_sel;
    logic                    addr_hit;
    logic                    access;
    logic                    wr_en;
    logic                    check_en_q;
    logic [`XLEN-1:0]        fault_addr_q;
    logic [`XLEN-1:0]        fault_cnt_q;

    // Access phase of an APB transfer
    assign access  = psel_i & penable_i;
    assign wr_en   = access & pwrite_i;
    assign reg_sel = lsu_pkg::reg_addr_e'(paddr_i);

    // Offset decode
    always_comb begin
        case (reg_sel)
            lsu_pkg::REG_ADDR_CTRL,
            lsu_pkg::REG_ADDR_FAULT_ADDR,
            lsu_pkg::REG_ADDR_FAULT_CNT: addr_hit = 1'b1;
            default:                     addr_hit = 1'b0;
        endcase
    end

    // CTRL bit 0 enables the misalignment check and comes out of reset set
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            check_en_q <= 1'b1;
        end else if (wr_en && reg_sel == lsu_pkg::REG_ADDR_CTRL) begin
            check_en_q <= pwdata_i[0];
        end
    end

    // Last faulting address is read-only from APB
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fault_addr_q <= '0;
        end else if (fault_i) begin
            fault_addr_q <= fault_addr_i;
        end
    end

    // Any write to the fault counter clears it
    // A fault in the clearing cycle still counts once
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fault_cnt_q <= '0;
        end else if (fault_i) begin
            if (wr_en && reg_sel == lsu_pkg::REG_ADDR_FAULT_CNT) begin
                fault_cnt_q <= `XLEN'(1);
            end else begin
                fault_cnt_q <= fault_cnt_q + `XLEN'(1);
            end
        end else if (wr_en && reg_sel == lsu_pkg::REG_ADDR_FAULT_CNT) begin
            fault_cnt_q <= '0;
        end
    end

    // Read mux
    always_comb begin
        case (reg_sel)
            lsu_pkg::REG_ADDR_CTRL:       prdata_o = {{(`XLEN-1){1'b0}}, check_en_q};
            lsu_pkg::REG_ADDR_FAULT_ADDR: prdata_o = fault_addr_q;
            lsu_pkg::REG_ADDR_FAULT_CNT:  prdata_o = fault_cnt_q;
            default:                      prdata_o = '0;
        endcase
    end

    // Zero wait states
    assign pready_o   = 1'b1;
    assign pslverr_o  = access & ~addr_hit;
    assign check_en_o = check_en_q;

    // Setup phase is followed by the access phase to the same offset
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (psel_i && !penable_i) |=> (psel_i && penable_i && $stable(paddr_i)))
        else $error("lsu_csr_apb: setup phase not followed by a matching access phase");

endmodule : lsu_csr_apb

/* rtl/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

    // Load kind carried from execute
    // NONE means no load in flight
    typedef enum logic [2:0] {
        LD_OPS_NONE = 3'd0,
        LD_OPS_LB   = 3'd1,
        LD_OPS_LBU  = 3'd2,
        LD_OPS_LH   = 3'd3,
        LD_OPS_LHU  = 3'd4,
        LD_OPS_LW   = 3'd5
    } ld_ops_e;

    // Store kind carried from execute
    // Also tells the memory which byte lanes to write
    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'd0,
        ST_OPS_SB   = 2'd1,
        ST_OPS_SH   = 2'd2,
        ST_OPS_SW   = 2'd3
    } st_ops_e;

    // Register map of the APB block
    // Each value is the register's APB byte offset
    typedef enum logic [7:0] {
        REG_ADDR_CTRL       = `REG_CTRL,
        REG_ADDR_FAULT_ADDR = `REG_FAULT_ADDR,
        REG_ADDR_FAULT_CNT  = `REG_FAULT_CNT
    } reg_addr_e;

endpackage : lsu_pkg

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // Execute side
    input  lsu_pkg::ld_ops_e     ld_ops_i,
    input  lsu_pkg::st_ops_e     st_ops_i,
    input  logic [`XLEN-1:0]     addr_i,
    input  logic [`XLEN-1:0]     w_data_i,
    input  logic [4:0]           rd_addr_i,

    // Writeback side
    output logic                 done_o,
    output logic                 fault_o,
    output logic                 wrb_valid_o,
    output logic [`XLEN-1:0]     wrb_data_o,
    output logic [4:0]           wrb_rd_addr_o,

    // APB configuration port
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [7:0]           paddr_i,
    input  logic [`XLEN-1:0]     pwdata_i,
    output logic [`XLEN-1:0]     prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o
);

    logic                check_en;
    logic [`XLEN-1:0]    fault_addr;

    // LSU to memory bus
    dbus_if u_dbus ();

    lsu u_lsu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .exe_ld_ops_i  (ld_ops_i),
        .exe_st_ops_i  (st_ops_i),
        .exe_addr_i    (addr_i),
        .exe_w_data_i  (w_data_i),
        .exe_rd_addr_i (rd_addr_i),
        .dbus          (u_dbus.master),
        .check_en_i    (check_en),
        .fault_o       (fault_o),
        .fault_addr_o  (fault_addr),
        .done_o        (done_o),
        .wrb_valid_o   (wrb_valid_o),
        .wrb_data_o    (wrb_data_o),
        .wrb_rd_addr_o (wrb_rd_addr_o)
    );

    // Fault pulse feeds both the port and the register block
    lsu_csr_apb u_csr (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .fault_i      (fault_o),
        .fault_addr_i (fault_addr),
        .check_en_o   (check_en)
    );

    dmem u_dmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dbus    (u_dbus.slave)
    );

endmodule : lsu_top

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator, run it, and scan the log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_lsu_top -o sim_lsu || exit 1
./obj_dir/sim_lsu > sim.log 2>&1 ; cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset low for a few edges, released just after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

/* verif/tb_lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu_top;

    // Cycle budget for any single wait
    localparam int TMO = 20;
    // Input drive offset after the rising edge
    localparam int DLY = 2;

    logic                 clk;
    logic                 rst_n;
    lsu_pkg::ld_ops_e     ld_ops_i;
    lsu_pkg::st_ops_e     st_ops_i;
    logic [`XLEN-1:0]     addr_i;
    logic [`XLEN-1:0]     w_data_i;
    logic [4:0]           rd_addr_i;
    logic                 done_o;
    logic                 fault_o;
    logic                 wrb_valid_o;
    logic [`XLEN-1:0]     wrb_data_o;
    logic [4:0]           wrb_rd_addr_o;
    logic                 psel_i;
    logic                 penable_i;
    logic                 pwrite_i;
    logic [7:0]           paddr_i;
    logic [`XLEN-1:0]     pwdata_i;
    logic [`XLEN-1:0]     prdata_o;
    logic                 pready_o;
    logic                 pslverr_o;

    // Memory model and expected register state
    logic [`XLEN-1:0]     model [`DMEM_WORDS];
    logic                 chk_en_m;
    logic [`XLEN-1:0]     fault_addr_m;
    int                   fault_cnt_m;
    logic [31:0]          rng;

    // Expectation handed from stimulus to the compare process
    logic                 pending;
    int                   cyc;
    int                   exp_lat;
    logic                 exp_fault;
    logic                 exp_valid;
    logic [`XLEN-1:0]     exp_data;
    logic [4:0]           exp_rd;

    int                   checks;
    int                   errors;
    int                   timeouts;

    tb_clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    lsu_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .ld_ops_i      (ld_ops_i),
        .st_ops_i      (st_ops_i),
        .addr_i        (addr_i),
        .w_data_i      (w_data_i),
        .rd_addr_i     (rd_addr_i),
        .done_o        (done_o),
        .fault_o       (fault_o),
        .wrb_valid_o   (wrb_valid_o),
        .wrb_data_o    (wrb_data_o),
        .wrb_rd_addr_o (wrb_rd_addr_o),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o)
    );

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected load value and fault flag for one access against the model word
    function automatic logic [31:0] ref_access(input lsu_pkg::ld_ops_e ld,
            input lsu_pkg::st_ops_e st, input logic [31:0] addr,
            input logic [31:0] word, input logic chk, output logic fault);
        logic [7:0]  b;
        logic [15:0] h;
        logic        half;
        logic        full;
        b    = word[8 * addr[1:0] +: 8];
        // Check-off rule: halfword by bit 1, word ignores bits 1:0
        h    = word[16 * addr[1] +: 16];
        half = (ld == lsu_pkg::LD_OPS_LH) || (ld == lsu_pkg::LD_OPS_LHU) ||
               (st == lsu_pkg::ST_OPS_SH);
        full = (ld == lsu_pkg::LD_OPS_LW) || (st == lsu_pkg::ST_OPS_SW);
        fault = chk && ((half && addr[0]) || (full && (addr[1:0] != 2'b00)));
        case (ld)
            lsu_pkg::LD_OPS_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LD_OPS_LBU: return {24'h0, b};
            lsu_pkg::LD_OPS_LH:  return {{16{h[15]}}, h};
            lsu_pkg::LD_OPS_LHU: return {16'h0, h};
            lsu_pkg::LD_OPS_LW:  return word;
            default:             return 32'h0;
        endcase
    endfunction

    // Model word after a store lands
    function automatic logic [31:0] merge_store(input lsu_pkg::st_ops_e st,
            input logic [31:0] addr, input logic [31:0] wd, input logic [31:0] word);
        logic [31:0] w;
        w = word;
        case (st)
            lsu_pkg::ST_OPS_SB: w[8 * addr[1:0] +: 8] = wd[7:0];
            lsu_pkg::ST_OPS_SH: w[16 * addr[1] +: 16] = wd[15:0];
            lsu_pkg::ST_OPS_SW: w = wd;
            default:            w = word;
        endcase
        return w;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR t=%0t %s got %08h expected %08h", $time, name, got, exp);
            errors++;
        end
    endtask

    // One APB transfer, setup then access phase
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
            output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        #DLY;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #DLY;
        penable_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready_o && n < TMO) begin
            n++;
            @(negedge clk);
        end
        if (!pready_o) begin
            $display("Timeout: APB transfer to offset %02h never completed", addr);
            timeouts++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #DLY;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Register read with an expected value, mapped offsets only
    task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_val("prdata_o", rd, exp);
        check_val("pslverr_o", 32'(err), 32'd0);
    endtask

    // Present one request, hold it until done_o, then retire it
    task automatic do_access(input lsu_pkg::ld_ops_e ld, input lsu_pkg::st_ops_e st,
            input logic [31:0] addr, input logic [31:0] wdata, input logic [4:0] rd);
        logic f;
        int   n;
        exp_data  = ref_access(ld, st, addr, model[addr[9:2]], chk_en_m, f);
        exp_fault = f;
        exp_valid = (ld != lsu_pkg::LD_OPS_NONE) && !f;
        exp_rd    = rd;
        // Faults finish in the first cycle, memory needs one more
        exp_lat   = f ? 0 : 1;
        @(posedge clk);
        #DLY;
        ld_ops_i  = ld;
        st_ops_i  = st;
        addr_i    = addr;
        w_data_i  = wdata;
        rd_addr_i = rd;
        cyc       = 0;
        pending   = 1'b1;
        n = 0;
        @(negedge clk);
        while (!done_o && n < TMO) begin
            n++;
            @(negedge clk);
        end
        if (!done_o) begin
            $display("Timeout: no done_o for access at address %08h", addr);
            timeouts++;
        end
        if (f) begin
            fault_cnt_m++;
            fault_addr_m = addr;
        end else if (st != lsu_pkg::ST_OPS_NONE) begin
            model[addr[9:2]] = merge_store(st, addr, wdata, model[addr[9:2]]);
        end
        @(posedge clk);
        #DLY;
        ld_ops_i = lsu_pkg::LD_OPS_NONE;
        st_ops_i = lsu_pkg::ST_OPS_NONE;
        pending  = 1'b0;
    endtask

    // Compare process, one look per cycle at the falling edge
    always @(negedge clk) begin
        if (pending) begin
            if (cyc == exp_lat) begin
                check_val("done_o", 32'(done_o), 32'd1);
                check_val("fault_o", 32'(fault_o), 32'(exp_fault));
                check_val("wrb_valid_o", 32'(wrb_valid_o), 32'(exp_valid));
                if (exp_valid) begin
                    check_val("wrb_data_o", wrb_data_o, exp_data);
                    check_val("wrb_rd_addr_o", 32'(wrb_rd_addr_o), 32'(exp_rd));
                end
            end else if (cyc < exp_lat) begin
                // Too early for completion
                check_val("done_o", 32'(done_o), 32'd0);
            end
            cyc = cyc + 1;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] rd;
        logic        err;
        int          n;
        ld_ops_i     = lsu_pkg::LD_OPS_NONE;
        st_ops_i     = lsu_pkg::ST_OPS_NONE;
        addr_i       = '0;
        w_data_i     = '0;
        rd_addr_i    = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        rng          = 32'h54e6328f;
        chk_en_m     = 1'b1;
        fault_addr_m = '0;
        fault_cnt_m  = 0;
        pending      = 1'b0;
        cyc          = 0;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model[i] = '0;
        end

        n = 0;
        @(posedge clk);
        while (!rst_n && n < TMO) begin
            n++;
            @(posedge clk);
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end

        // Idle outputs and register defaults
        @(negedge clk);
        check_val("done_o", 32'(done_o), 32'd0);
        check_val("fault_o", 32'(fault_o), 32'd0);
        check_val("wrb_valid_o", 32'(wrb_valid_o), 32'd0);
        reg_check(`REG_CTRL, 32'd1);
        reg_check(`REG_FAULT_ADDR, 32'd0);
        reg_check(`REG_FAULT_CNT, 32'd0);

        // Aligned word store and load back
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            a   = {22'h0, rng[9:2], 2'b00};
            rng = xorshift32(rng);
            do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SW, a, rng, 5'd0);
            do_access(lsu_pkg::LD_OPS_LW, lsu_pkg::ST_OPS_NONE, a, 32'h0, rng[4:0]);
        end

        // Byte and halfword stores, then every lane and extension
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            a   = {22'h0, rng[9:2], 2'b00};
            d   = xorshift32(rng);
            rng = d;
            do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SB, a + {30'h0, d[9:8]}, d, 5'd0);
            do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SH, a + {30'h0, d[10], 1'b0},
                      d >> 16, 5'd0);
            for (int off = 0; off < 4; off++) begin
                do_access(lsu_pkg::LD_OPS_LB, lsu_pkg::ST_OPS_NONE, a + 32'(off), 32'h0,
                          5'(off + 1));
                do_access(lsu_pkg::LD_OPS_LBU, lsu_pkg::ST_OPS_NONE, a + 32'(off), 32'h0,
                          5'(off + 5));
                if (off % 2 == 0) begin
                    do_access(lsu_pkg::LD_OPS_LH, lsu_pkg::ST_OPS_NONE, a + 32'(off), 32'h0,
                              5'(off + 9));
                    do_access(lsu_pkg::LD_OPS_LHU, lsu_pkg::ST_OPS_NONE, a + 32'(off), 32'h0,
                              5'(off + 13));
                end
            end
        end

        // Misaligned accesses fault while the check is on
        rng = xorshift32(rng);
        a   = {22'h0, rng[9:2], 2'b00};
        do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SW, a, rng, 5'd0);
        do_access(lsu_pkg::LD_OPS_LH, lsu_pkg::ST_OPS_NONE, a + 1, 32'h0, 5'd3);
        do_access(lsu_pkg::LD_OPS_LW, lsu_pkg::ST_OPS_NONE, a + 2, 32'h0, 5'd4);
        do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SW, a + 3, ~rng, 5'd0);
        // Word must still hold the aligned store
        do_access(lsu_pkg::LD_OPS_LW, lsu_pkg::ST_OPS_NONE, a, 32'h0, 5'd5);
        reg_check(`REG_FAULT_ADDR, fault_addr_m);
        reg_check(`REG_FAULT_CNT, 32'(fault_cnt_m));

        // Check off, misaligned accesses go through
        apb_xfer(1'b1, `REG_CTRL, 32'h0, rd, err);
        chk_en_m = 1'b0;
        reg_check(`REG_CTRL, 32'd0);
        do_access(lsu_pkg::LD_OPS_LH, lsu_pkg::ST_OPS_NONE, a + 3, 32'h0, 5'd6);
        do_access(lsu_pkg::LD_OPS_LHU, lsu_pkg::ST_OPS_NONE, a + 1, 32'h0, 5'd7);
        rng = xorshift32(rng);
        do_access(lsu_pkg::LD_OPS_NONE, lsu_pkg::ST_OPS_SW, a + 2, rng, 5'd0);
        do_access(lsu_pkg::LD_OPS_LW, lsu_pkg::ST_OPS_NONE, a + 1, 32'h0, 5'd8);
        reg_check(`REG_FAULT_CNT, 32'(fault_cnt_m));
        // Any write clears the counter
        apb_xfer(1'b1, `REG_FAULT_CNT, 32'h5, rd, err);
        fault_cnt_m = 0;
        reg_check(`REG_FAULT_CNT, 32'd0);

        // Unmapped offset answers with an error
        apb_xfer(1'b0, 8'h0C, 32'h0, rd, err);
        check_val("pslverr_o", 32'(err), 32'd1);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_lsu_top
